// ==== src/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width
`define XLEN 64

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// reset and ebreak target
`define BOOT_ADDR 64'h0000_0000_8000_0000

`endif

// ==== src/rv_pkg.sv ====
package rv_pkg;

   // major opcodes that affect control flow
   typedef enum logic [6:0] {
      OP_BRANCH = 7'b1100011,
      OP_JAL    = 7'b1101111,
      OP_JALR   = 7'b1100111,
      OP_SYSTEM = 7'b1110011
   } opcode_e;

   // funct3 of the conditional branches, 010 and 011 unused
   typedef enum logic [2:0] {
      BR_EQ  = 3'b000,
      BR_NE  = 3'b001,
      BR_LT  = 3'b100,
      BR_GE  = 3'b101,
      BR_LTU = 3'b110,
      BR_GEU = 3'b111
   } branch_op_e;

   // immediate formats
   typedef enum logic [1:0] {
      IMM_I = 2'd0,
      IMM_B = 2'd1,
      IMM_J = 2'd2
   } imm_sel_e;

endpackage

// ==== src/branch_decode.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module branch_decode (
   input  logic [31:0]                instr,
   input  logic                       ena,
   output logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
   output logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
   output logic [`REG_ADDR_WIDTH-1:0] rd_addr,
   output rv_pkg::imm_sel_e           imm_sel,
   output rv_pkg::branch_op_e         branch_op,
   output logic                       is_branch,
   output logic                       is_jal,
   output logic                       is_jalr,
   output logic                       is_ebreak,
   output logic                       link_en
);
   import rv_pkg::*;

   opcode_e    opcode;
   logic [2:0] funct3;
   logic       funct3_ok;

   assign opcode   = opcode_e'(instr[6:0]);
   assign funct3   = instr[14:12];
   assign rd_addr  = instr[11:7];
   assign rs1_addr = instr[19:15];
   assign rs2_addr = instr[24:20];

   assign branch_op = branch_op_e'(funct3);

   always_comb begin
      case (funct3)
         3'b010, 3'b011: funct3_ok = 1'b0; // reserved encodings
         default:        funct3_ok = 1'b1;
      endcase
   end

   always_comb begin
      is_branch = 1'b0;
      is_jal    = 1'b0;
      is_jalr   = 1'b0;
      is_ebreak = 1'b0;
      imm_sel   = IMM_I;
      case (opcode)
         OP_BRANCH: begin
            imm_sel   = IMM_B;
            is_branch = funct3_ok; // bad funct3 falls through to pc+4
         end
         OP_JAL: begin
            imm_sel = IMM_J;
            is_jal  = 1'b1;
         end
         OP_JALR: begin
            is_jalr = 1'b1;
         end
         OP_SYSTEM: begin
            // ebreak only, every other field must be zero
            is_ebreak = (instr[31:20] == 12'h001) && (instr[19:7] == 13'd0);
         end
         default: begin
            imm_sel = IMM_I;
         end
      endcase
   end

   // link only while running and not into x0
   assign link_en = ena & (is_jal | is_jalr) & (rd_addr != '0);

endmodule

// ==== src/imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module imm_gen (
   input  logic [31:0]       instr,
   input  rv_pkg::imm_sel_e  imm_sel,
   output logic [`XLEN-1:0]  imm
);
   import rv_pkg::*;

   logic [11:0] imm_i;
   logic [12:0] imm_b;
   logic [20:0] imm_j;

   assign imm_i = instr[31:20];

   // scattered B fields, lsb always zero
   assign imm_b = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

   // scattered J fields, lsb always zero
   assign imm_j = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      case (imm_sel)
         IMM_B: begin
            imm = {{(`XLEN-13){imm_b[12]}}, imm_b};
         end
         IMM_J: begin
            imm = {{(`XLEN-21){imm_j[20]}}, imm_j};
         end
         default: begin
            imm = {{(`XLEN-12){imm_i[11]}}, imm_i}; // jalr
         end
      endcase
   end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module reg_file (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       ena,
   input  logic                       wr_en,
   input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
   input  logic [`XLEN-1:0]           wr_data,
   input  logic                       link_en,
   input  logic [`REG_ADDR_WIDTH-1:0] rd_addr,
   input  logic [`XLEN-1:0]           link_data,
   input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
   input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
   output logic [`XLEN-1:0]           rs1_data,
   output logic [`XLEN-1:0]           rs2_data
);

   logic [`XLEN-1:0]           regs [1:`REG_COUNT-1]; // x0 has no storage
   logic                       wb_en;
   logic [`REG_ADDR_WIDTH-1:0] wb_addr;
   logic [`XLEN-1:0]           wb_data;

   // link has priority, external port only while stalled
   assign wb_en   = link_en | (~ena & wr_en);
   assign wb_addr = link_en ? rd_addr : wr_addr;
   assign wb_data = link_en ? link_data : wr_data;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en && (wb_addr != '0)) begin
         regs[wb_addr] <= wb_data;
      end
   end

   assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== src/branch_compare.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module branch_compare (
   input  rv_pkg::branch_op_e branch_op,
   input  logic [`XLEN-1:0]   rs1_data,
   input  logic [`XLEN-1:0]   rs2_data,
   output logic               taken
);
   import rv_pkg::*;

   logic eq;
   logic lt_s;
   logic lt_u;

   assign eq   = (rs1_data == rs2_data);
   assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
   assign lt_u = (rs1_data < rs2_data);

   always_comb begin
      case (branch_op)
         BR_EQ:   taken = eq;
         BR_NE:   taken = ~eq;
         BR_LT:   taken = lt_s;
         BR_GE:   taken = ~lt_s; // signed >=
         BR_LTU:  taken = lt_u;
         BR_GEU:  taken = ~lt_u;
         default: taken = 1'b0;  // reserved funct3
      endcase
   end

endmodule

// ==== src/next_pc_mux.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module next_pc_mux (
   input  logic             clk,
   input  logic             rst,
   input  logic             ena,
   input  logic             is_branch,
   input  logic             is_jal,
   input  logic             is_jalr,
   input  logic             is_ebreak,
   input  logic             taken,
   input  logic [`XLEN-1:0] imm,
   input  logic [`XLEN-1:0] rs1_data,
   output logic [`XLEN-1:0] pc,
   output logic [`XLEN-1:0] link_data
);

   logic [`XLEN-1:0] pc_plus4;
   logic [`XLEN-1:0] jalr_sum;
   logic [`XLEN-1:0] next_pc;

   assign pc_plus4  = pc + `XLEN'd4;
   assign jalr_sum  = rs1_data + imm;
   assign link_data = pc_plus4;

   always_comb begin
      if (is_branch && taken) begin
         next_pc = pc + imm;
      end else if (is_branch) begin
         next_pc = pc_plus4; // not taken
      end else if (is_jal) begin
         next_pc = pc + imm;
      end else if (is_jalr) begin
         next_pc = {jalr_sum[`XLEN-1:1], 1'b0};
      end else if (is_ebreak) begin
         next_pc = `BOOT_ADDR;
      end else begin
         next_pc = pc_plus4;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= `BOOT_ADDR;
      end else if (ena) begin
         pc <= next_pc;
      end
   end

endmodule

// ==== src/pc_unit_top.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module pc_unit_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       ena,
   input  logic [31:0]                instr,
   input  logic                       wr_en,
   input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
   input  logic [`XLEN-1:0]           wr_data,
   output logic [`XLEN-1:0]           pc
);
   import rv_pkg::*;

   logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
   logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
   logic [`REG_ADDR_WIDTH-1:0] rd_addr;
   imm_sel_e                   imm_sel;
   branch_op_e                 branch_op;
   logic                       is_branch;
   logic                       is_jal;
   logic                       is_jalr;
   logic                       is_ebreak;
   logic                       link_en;
   logic [`XLEN-1:0]           rs1_data;
   logic [`XLEN-1:0]           rs2_data;
   logic [`XLEN-1:0]           imm;
   logic                       taken;
   logic [`XLEN-1:0]           link_data;

   branch_decode u_decode (
      .instr     (instr),
      .ena       (ena),
      .rs1_addr  (rs1_addr),
      .rs2_addr  (rs2_addr),
      .rd_addr   (rd_addr),
      .imm_sel   (imm_sel),
      .branch_op (branch_op),
      .is_branch (is_branch),
      .is_jal    (is_jal),
      .is_jalr   (is_jalr),
      .is_ebreak (is_ebreak),
      .link_en   (link_en)
   );

   imm_gen u_imm (
      .instr   (instr),
      .imm_sel (imm_sel),
      .imm     (imm)
   );

   reg_file u_regs (
      .clk       (clk),
      .rst       (rst),
      .ena       (ena),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .link_en   (link_en),
      .rd_addr   (rd_addr),
      .link_data (link_data),
      .rs1_addr  (rs1_addr),
      .rs2_addr  (rs2_addr),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data)
   );

   branch_compare u_cmp (
      .branch_op (branch_op),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data),
      .taken     (taken)
   );

   next_pc_mux u_npc (
      .clk       (clk),
      .rst       (rst),
      .ena       (ena),
      .is_branch (is_branch),
      .is_jal    (is_jal),
      .is_jalr   (is_jalr),
      .is_ebreak (is_ebreak),
      .taken     (taken),
      .imm       (imm),
      .rs1_data  (rs1_data),
      .pc        (pc),
      .link_data (link_data)
   );

endmodule

// ==== verif/pc_unit_assertions.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module pc_unit_assertions (
   input logic                       clk,
   input logic                       rst,
   input logic                       ena,
   input logic                       is_ebreak,
   input logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
   input logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
   input logic [`XLEN-1:0]           rs1_data,
   input logic [`XLEN-1:0]           rs2_data,
   input logic [`XLEN-1:0]           pc
);

   int fail_count = 0;

   reset_to_boot: assert property (@(posedge clk) rst |=> (pc == `BOOT_ADDR))
      else begin
         fail_count++;
         $error("pc is not the boot address after reset");
      end

   hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
      !ena |=> $stable(pc))
      else begin
         fail_count++;
         $error("pc moved while ena was low");
      end

   // x0 drops every write, so both read ports see zero
   x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
      ((rs1_addr != '0) || (rs1_data == '0)) && ((rs2_addr != '0) || (rs2_data == '0)))
      else begin
         fail_count++;
         $error("x0 read back a nonzero value");
      end

   ebreak_to_boot: assert property (@(posedge clk) disable iff (rst)
      (ena && is_ebreak) |=> (pc == `BOOT_ADDR))
      else begin
         fail_count++;
         $error("ebreak did not return pc to the boot address");
      end

endmodule

// ==== verif/pc_unit_tb.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module pc_unit_tb;
   import rv_pkg::*;

   localparam int RUN_CYCLES  = 2000;
   localparam int BURST_LEN   = 3;
   localparam int LOAD_CYCLES = `REG_COUNT + (RUN_CYCLES / 100) * BURST_LEN;
   localparam int CYCLE_LIMIT = RUN_CYCLES + LOAD_CYCLES + 200;

   logic                       clk;
   logic                       rst;
   logic                       ena;
   logic [31:0]                instr;
   logic                       wr_en;
   logic [`REG_ADDR_WIDTH-1:0] wr_addr;
   logic [`XLEN-1:0]           wr_data;
   logic [`XLEN-1:0]           pc;

   logic [`XLEN-1:0] m_pc; // reference model state
   logic [`XLEN-1:0] m_regs [0:`REG_COUNT-1];
   integer           seed;
   int               cycles = 0;

   pc_unit_top DUT (
      .clk     (clk),
      .rst     (rst),
      .ena     (ena),
      .instr   (instr),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .pc      (pc)
   );

   bind pc_unit_top pc_unit_assertions u_sva (
      .clk       (clk),
      .rst       (rst),
      .ena       (ena),
      .is_ebreak (is_ebreak),
      .rs1_addr  (rs1_addr),
      .rs2_addr  (rs2_addr),
      .rs1_data  (rs1_data),
      .rs2_data  (rs2_data),
      .pc        (pc)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
         $display("Errors found");
         $fatal(1, "cycle limit reached");
      end
   end

   task automatic check_pc;
      assert (pc == m_pc) else begin
         $display("error at %0t: pc is %h, expected %h", $time, pc, m_pc);
         $display("Errors found");
         $fatal(1, "pc mismatch");
      end
   endtask

   function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a,
                                         input logic [63:0] b);
      case (f3)
         BR_EQ:   return a == b;
         BR_NE:   return a != b;
         BR_LT:   return $signed(a) < $signed(b);
         BR_GE:   return $signed(a) >= $signed(b);
         BR_LTU:  return a < b;
         default: return a >= b; // geu
      endcase
   endfunction

   task automatic rand_value(output logic [63:0] v);
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      case (r3[2:0])
         3'd0:    v = '0;
         3'd1:    v = '1;
         3'd2:    v = 64'h8000_0000_0000_0000; // most negative
         3'd3:    v = 64'h7fff_ffff_ffff_ffff;
         3'd4:    v = 64'd1;
         default: v = {r1, r2};
      endcase
   endtask

   // one stalled cycle with an external write
   task automatic ext_write(input logic [4:0] addr, input logic [63:0] data);
      ena     = 1'b0;
      wr_en   = 1'b1;
      wr_addr = addr;
      wr_data = data;
      @(posedge clk);
      #2;
      if (addr != 5'd0) m_regs[addr] = data; // x0 drops writes
      check_pc();
   endtask

   task automatic reload_burst;
      logic [63:0] v;
      logic [31:0] r;
      for (int k = 0; k < BURST_LEN; k++) begin
         r = $random(seed);
         rand_value(v);
         ext_write(r[4:0], v);
      end
   endtask

   task automatic run_step;
      logic [31:0] r, f, pick, iv;
      logic [4:0]  rs1, rs2, rd;
      logic [2:0]  f3;
      logic [12:0] ib;
      logic [20:0] ij;
      logic [11:0] ii;
      logic [63:0] nxt, link_val;
      logic        link;
      r    = $random(seed);
      f    = $random(seed);
      pick = $random(seed);
      pick = pick % 32'd100;
      rs1  = r[4:0];
      rs2  = r[9:5];
      rd   = r[14:10];
      if (r[15] && r[16]) rs2 = rs1; // equal operands now and then
      ib       = {{7{f[6]}}, f[5:1], 1'b0}; // small offsets only
      ij       = {{14{f[7]}}, f[6:1], 1'b0};
      ii       = {{5{f[7]}}, f[6:0]};
      nxt      = m_pc + 64'd4;
      link_val = m_pc + 64'd4;
      link     = 1'b0;
      if (pick < 32'd25) begin
         f3 = r[19:17];
         if (pick >= 32'd20) f3 = {2'b01, r[17]}; // reserved funct3
         else if (f3 == 3'b010 || f3 == 3'b011) f3 = {1'b1, r[18:17]};
         iv = {ib[12], ib[10:5], rs2, rs1, f3, ib[4:1], ib[11], OP_BRANCH};
         if (pick < 32'd20 && branch_taken(f3, m_regs[rs1], m_regs[rs2]))
            nxt = m_pc + {{51{ib[12]}}, ib};
      end else if (pick < 32'd35) begin
         iv   = {ij[20], ij[10:1], ij[11], ij[19:12], rd, OP_JAL};
         nxt  = m_pc + {{43{ij[20]}}, ij};
         link = 1'b1;
      end else if (pick < 32'd45) begin
         iv     = {ii, rs1, 3'b000, rd, OP_JALR};
         nxt    = m_regs[rs1] + {{52{ii[11]}}, ii};
         nxt[0] = 1'b0;
         link   = 1'b1;
      end else if (pick < 32'd55) begin
         iv  = 32'h0010_0073; // ebreak
         nxt = `BOOT_ADDR;
      end else begin
         case (r[22:20])
            3'd0:    iv = {f[31:7], 7'b0110011};
            3'd1:    iv = {f[31:7], 7'b0010011};
            3'd2:    iv = {f[31:7], 7'b0000011};
            3'd3:    iv = {f[31:7], 7'b0100011};
            3'd4:    iv = {f[31:7], 7'b0110111};
            3'd5:    iv = {f[31:7], 7'b0010111};
            3'd6:    iv = {f[31:7], 7'b0001111};
            default: iv = 32'h0000_0073; // ecall is just another opcode here
         endcase
      end
      instr   = iv;
      ena     = 1'b1;
      wr_en   = r[23]; // must be ignored while running
      wr_addr = r[28:24];
      wr_data = {f, r};
      @(posedge clk);
      #2;
      m_pc = nxt;
      if (link && rd != 5'd0) m_regs[rd] = link_val;
      check_pc();
   endtask

   initial begin
      logic [63:0] v;
      seed    = 32'h7781_d791;
      rst     = 1'b1;
      ena     = 1'b0;
      instr   = 32'd0;
      wr_en   = 1'b0;
      wr_addr = '0;
      wr_data = '0;
      m_pc    = `BOOT_ADDR;
      for (int i = 0; i < `REG_COUNT; i++) m_regs[i] = '0;
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;
      check_pc();
      for (int i = 0; i < `REG_COUNT; i++) begin
         rand_value(v);
         ext_write(i[4:0], v);
      end
      for (int n = 0; n < RUN_CYCLES; n++) begin
         if (n % 100 == 99) reload_burst();
         run_step();
      end
      ena   = 1'b0; // one more edge for the bound checks
      wr_en = 1'b0;
      @(posedge clk);
      #2;
      check_pc();
      if (DUT.u_sva.fail_count == 0) begin
         $display("No errors");
      end else begin
         $display("bound assertions failed %0d times", DUT.u_sva.fail_count);
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+src
src/rv_pkg.sv
src/branch_decode.sv
src/imm_gen.sv
src/reg_file.sv
src/branch_compare.sv
src/next_pc_mux.sv
src/pc_unit_top.sv
verif/pc_unit_assertions.sv
verif/pc_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pc unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module pc_unit_tb -o pc_unit_sim

./obj_dir/pc_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^No errors$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
